// ==== commit_stage.f ====
hw/commit_pkg.sv
hw/commit_buffer_if.sv
hw/commit_buffer.sv
hw/commit_controller.sv
hw/commit_csr.sv
hw/commit_stage_top.sv
verif/commit_checker.sv
verif/commit_stage_tb.sv

// ==== hw/commit_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_buffer
    import commit_pkg::*;
#(
    parameter int BUFFER_DEPTH = 8
) (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,
    input  wire logic          flush_i,
    input  wire logic          stall_i,

    // Result coming in from the execution path
    input  wire logic          push_i,
    input  wire data_word_t    result_i,
    input  wire instr_packet_t ipacket_i,

    // Register written by the other buffer in this cycle
    input  wire logic          invalidate_i,
    input  wire reg_addr_t     invalid_reg_i,

    commit_buffer_if.buffer    ctl
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    // Push and pop only count while the stage is not held
    logic push_en;
    logic pop_en;

    assign push_en = push_i & ~stall_i;
    assign pop_en  = ctl.read & ~stall_i;

    // ==================================================
    // FIFO pointers and status
    // ==================================================

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_next;
    logic [PTR_W-1:0] rd_ptr_next;

    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_ptr_next = rd_ptr + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            ctl.empty <= 1'b1;
            ctl.full  <= 1'b0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr_next;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr_next;
            end
            // A push and a pop in the same cycle leave the occupancy unchanged
            case ({push_en, pop_en})
                2'b10: begin
                    ctl.empty <= 1'b0;
                    ctl.full  <= (wr_ptr_next == rd_ptr);
                end
                2'b01: begin
                    ctl.full  <= 1'b0;
                    ctl.empty <= (rd_ptr_next == wr_ptr);
                end
                default: ;
            endcase
        end
    end

    // ==================================================
    // Entry storage
    // ==================================================

    data_word_t    result_mem [BUFFER_DEPTH];
    instr_packet_t packet_mem [BUFFER_DEPTH];
    instr_packet_t head_pkt;

    always_ff @(posedge clk_i) begin
        if (push_en) begin
            result_mem[wr_ptr] <= result_i;
            packet_mem[wr_ptr] <= ipacket_i;
        end
    end

    // The head is read straight from the array, no extra stage
    assign head_pkt         = packet_mem[rd_ptr];
    assign ctl.head_result  = result_mem[rd_ptr];
    assign ctl.head_ipacket = head_pkt;

    // ==================================================
    // Forwarding state
    // ==================================================

    // Latest value per register together with the tag that produced it
    data_word_t  fwd_store [32];
    rob_tag_t    tag_store [32];
    logic [31:0] valid_q;
    logic        reg_write;
    logic        pop_owns;

    assign reg_write = push_en & ~ipacket_i.is_store;

    // The popped entry only owns the value if nothing younger overwrote it
    assign pop_owns = pop_en & ~head_pkt.is_store &
                      (tag_store[head_pkt.reg_dest] == head_pkt.rob_tag) &
                      ~(reg_write & (ipacket_i.reg_dest == head_pkt.reg_dest));

    always_ff @(posedge clk_i) begin
        if (reg_write) begin
            fwd_store[ipacket_i.reg_dest] <= result_i;
            tag_store[ipacket_i.reg_dest] <= ipacket_i.rob_tag;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
        end else if (!stall_i) begin
            if (reg_write) begin
                valid_q[ipacket_i.reg_dest] <= 1'b1;
            end
            // Once committed the value lives in the register file instead
            if (pop_owns) begin
                valid_q[head_pkt.reg_dest] <= 1'b0;
            end
            // The other buffer now holds the youngest copy of this register
            if (invalidate_i) begin
                valid_q[invalid_reg_i] <= 1'b0;
            end
        end
    end

    // Lookups answer in the same cycle, x0 is always a valid zero
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (ctl.fwd_src[i] == '0) begin
                ctl.fwd_result[i] = '0;
                ctl.fwd_valid[i]  = 1'b1;
            end else begin
                ctl.fwd_result[i] = fwd_store[ctl.fwd_src[i]];
                ctl.fwd_valid[i]  = valid_q[ctl.fwd_src[i]];
            end
        end
    end

    // The execution path must watch full before it pushes
    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !ctl.full)
        else $error("commit_buffer: push into a full buffer");

    // The controller may only pop an entry that exists
    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_en |-> !ctl.empty)
        else $error("commit_buffer: pop from an empty buffer");

    // A result offered during hold would be dropped
    assert property (@(posedge clk_i) disable iff (!rst_n_i) stall_i |-> !push_i)
        else $error("commit_buffer: push lost while the stage is held");

endmodule : commit_buffer

`default_nettype wire

// ==== hw/commit_buffer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface commit_buffer_if
    import commit_pkg::*;
();

    // Oldest entry of the buffer, valid while empty is low
    data_word_t    head_result;
    instr_packet_t head_ipacket;

    // Registered occupancy flags
    logic empty;
    logic full;

    // Pop request from the controller
    logic read;

    // Two operand lookups from the issue stage, answered combinationally
    reg_addr_t  fwd_src    [2];
    data_word_t fwd_result [2];
    logic       fwd_valid  [2];

    modport buffer (
        output head_result, head_ipacket, empty, full, fwd_result, fwd_valid,
        input  read, fwd_src
    );

    modport controller (
        input  head_result, head_ipacket, empty, full, fwd_result, fwd_valid,
        output read, fwd_src
    );

endinterface : commit_buffer_if

`default_nettype wire

// ==== hw/commit_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_controller
    import commit_pkg::*;
(
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           flush_i,
    input  wire logic           stall_i,

    commit_buffer_if.controller alu,
    commit_buffer_if.controller ld,

    // Operand lookups from the issue stage
    input  wire reg_addr_t      fwd_src_i    [2],
    output data_word_t          fwd_result_o [2],
    output logic                fwd_valid_o  [2],

    // One pulse per retired instruction, stores included
    output logic                commit_o,

    // Register file writeback
    output logic                wb_valid_o,
    output reg_addr_t           wb_reg_o,
    output data_word_t          wb_data_o,
    output rob_tag_t            wb_tag_o
);

    // ==================================================
    // In-order head selection
    // ==================================================

    rob_tag_t next_tag;
    logic     alu_hit;
    logic     ld_hit;
    logic     pop;

    // A head may retire only when it carries the tag the core waits for
    assign alu_hit = ~alu.empty & (alu.head_ipacket.rob_tag == next_tag);
    assign ld_hit  = ~ld.empty & (ld.head_ipacket.rob_tag == next_tag);

    assign alu.read = alu_hit & ~stall_i & ~flush_i;
    assign ld.read  = ld_hit & ~stall_i & ~flush_i;
    assign pop      = alu.read | ld.read;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            next_tag   <= '0;
            wb_valid_o <= 1'b0;
            commit_o   <= 1'b0;
        end else begin
            if (pop) begin
                next_tag <= next_tag + 1'b1;
            end
            commit_o   <= pop;
            // A store retires without touching the register file
            wb_valid_o <= alu.read ? ~alu.head_ipacket.is_store :
                          ld.read  ? ~ld.head_ipacket.is_store  : 1'b0;
        end
    end

    // Writeback payload is captured on every pop
    always_ff @(posedge clk_i) begin
        if (pop) begin
            wb_reg_o  <= alu.read ? alu.head_ipacket.reg_dest : ld.head_ipacket.reg_dest;
            wb_data_o <= alu.read ? alu.head_result : ld.head_result;
            wb_tag_o  <= next_tag;
        end
    end

    // ==================================================
    // Forwarding merge
    // ==================================================

    // Cross invalidation leaves at most one valid source, ALU wins anyway
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            alu.fwd_src[i] = fwd_src_i[i];
            ld.fwd_src[i]  = fwd_src_i[i];
            fwd_valid_o[i] = alu.fwd_valid[i] | ld.fwd_valid[i];
            if (alu.fwd_valid[i]) begin
                fwd_result_o[i] = alu.fwd_result[i];
            end else if (ld.fwd_valid[i]) begin
                fwd_result_o[i] = ld.fwd_result[i];
            end else begin
                fwd_result_o[i] = '0;
            end
        end
    end

    // Each tag is issued once, so only one buffer may hold it at its head
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(alu_hit && ld_hit))
        else $error("commit_controller: both heads carry tag %0d", next_tag);

endmodule : commit_controller

`default_nettype wire

// ==== hw/commit_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_csr
    import commit_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    // Wishbone classic slave
    input  wire logic        wb_cyc_i,
    input  wire logic        wb_stb_i,
    input  wire logic        wb_we_i,
    input  wire logic [1:0]  wb_adr_i,
    input  wire logic [31:0] wb_dat_i,
    output logic      [31:0] wb_dat_o,
    output logic             wb_ack_o,

    // Full and empty flags of both buffers
    input  wire logic [3:0]  status_i,
    input  wire logic        commit_i,

    output logic             flush_o,
    output logic             hold_o
);

    // ==================================================
    // Bus handshake
    // ==================================================

    logic        access;
    logic        write;
    csr_ctrl_t   ctrl_q;
    logic [31:0] count_q;

    // The first cycle of a request is served, the ack cycle is not
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign write  = access & wb_we_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    // Read data is captured together with the ack
    always_ff @(posedge clk_i) begin
        if (access) begin
            case (wb_adr_i)
                CSR_CTRL_ADDR:   wb_dat_o <= {30'b0, ctrl_q};
                CSR_STATUS_ADDR: wb_dat_o <= {28'b0, status_i};
                CSR_COUNT_ADDR:  wb_dat_o <= count_q;
                default:         wb_dat_o <= '0;
            endcase
        end
    end

    // ==================================================
    // Registers
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= '0;
        end else begin
            // Flush is a single cycle pulse, hold stays until rewritten
            ctrl_q.flush <= write & (wb_adr_i == CSR_CTRL_ADDR) & wb_dat_i[0];
            if (write && (wb_adr_i == CSR_CTRL_ADDR)) begin
                ctrl_q.hold <= wb_dat_i[1];
            end
        end
    end

    // Commit counter, cleared by a flush or by any write to it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || ctrl_q.flush) begin
            count_q <= '0;
        end else if (write && (wb_adr_i == CSR_COUNT_ADDR)) begin
            count_q <= '0;
        end else if (commit_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign flush_o = ctrl_q.flush;
    assign hold_o  = ctrl_q.hold;

endmodule : commit_csr

`default_nettype wire

// ==== hw/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    // ==================================================
    // Datapath types
    // ==================================================

    // Result word produced by either execution path
    typedef logic [31:0] data_word_t;

    // Architectural register index, x0 is hard-wired to zero
    typedef logic [4:0] reg_addr_t;

    // Reorder tag that wraps modulo 64 and fixes the commit order
    typedef logic [5:0] rob_tag_t;

    // Bookkeeping that travels with every result through the buffers
    typedef struct packed {
        reg_addr_t reg_dest;
        rob_tag_t  rob_tag;
        // Stores retire in order here but never write a register
        logic      is_store;
    } instr_packet_t;

    // ==================================================
    // Register block map
    // ==================================================

    // Word offsets on the Wishbone address bus
    localparam logic [1:0] CSR_CTRL_ADDR   = 2'd0;
    localparam logic [1:0] CSR_STATUS_ADDR = 2'd1;
    localparam logic [1:0] CSR_COUNT_ADDR  = 2'd2;

    // Control word, flush sits in bit 0 and hold in bit 1
    typedef struct packed {
        logic hold;
        logic flush;
    } csr_ctrl_t;

endpackage : commit_pkg

`default_nettype wire

// ==== hw/commit_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_stage_top
    import commit_pkg::*;
#(
    parameter int BUFFER_DEPTH = 8
) (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,

    // ALU path results
    input  wire logic          alu_push_i,
    input  wire data_word_t    alu_result_i,
    input  wire instr_packet_t alu_packet_i,
    output logic               alu_full_o,

    // Load path results
    input  wire logic          ld_push_i,
    input  wire data_word_t    ld_result_i,
    input  wire instr_packet_t ld_packet_i,
    output logic               ld_full_o,

    // Operand forwarding for the issue stage
    input  wire reg_addr_t     fwd_src_i    [2],
    output data_word_t         fwd_result_o [2],
    output logic               fwd_valid_o  [2],

    // Register file writeback
    output logic               wb_valid_o,
    output reg_addr_t          wb_reg_o,
    output data_word_t         wb_data_o,
    output rob_tag_t           wb_tag_o,

    // Wishbone classic register port
    input  wire logic          wb_cyc_i,
    input  wire logic          wb_stb_i,
    input  wire logic          wb_we_i,
    input  wire logic [1:0]    wb_adr_i,
    input  wire logic [31:0]   wb_dat_i,
    output logic      [31:0]   wb_dat_o,
    output logic               wb_ack_o
);

    logic       flush;
    logic       hold;
    logic       commit;
    logic [3:0] status;

    commit_buffer_if alu_if ();
    commit_buffer_if ld_if ();

    // ==================================================
    // Commit buffers
    // ==================================================

    // Each buffer drops its copy when the other one writes the same register
    commit_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_alu_buffer (
        .clk_i, .rst_n_i, .flush_i(flush), .stall_i(hold),
        .push_i(alu_push_i), .result_i(alu_result_i), .ipacket_i(alu_packet_i),
        .invalidate_i(ld_push_i & ~ld_packet_i.is_store),
        .invalid_reg_i(ld_packet_i.reg_dest), .ctl(alu_if.buffer)
    );

    commit_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_ld_buffer (
        .clk_i, .rst_n_i, .flush_i(flush), .stall_i(hold),
        .push_i(ld_push_i), .result_i(ld_result_i), .ipacket_i(ld_packet_i),
        .invalidate_i(alu_push_i & ~alu_packet_i.is_store),
        .invalid_reg_i(alu_packet_i.reg_dest), .ctl(ld_if.buffer)
    );

    // ==================================================
    // Controller and register block
    // ==================================================

    commit_controller u_controller (
        .clk_i, .rst_n_i, .flush_i(flush), .stall_i(hold),
        .alu(alu_if.controller), .ld(ld_if.controller),
        .fwd_src_i, .fwd_result_o, .fwd_valid_o, .commit_o(commit),
        .wb_valid_o, .wb_reg_o, .wb_data_o, .wb_tag_o
    );

    // STATUS layout is ALU empty, ALU full, load empty, load full from bit 0
    assign status = {ld_if.full, ld_if.empty, alu_if.full, alu_if.empty};

    commit_csr u_csr (
        .clk_i, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o, .status_i(status), .commit_i(commit),
        .flush_o(flush), .hold_o(hold)
    );

    assign alu_full_o = alu_if.full;
    assign ld_full_o  = ld_if.full;

endmodule : commit_stage_top

`default_nettype wire

// ==== verif/commit_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_checker
    import commit_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,

    // Writeback port of the DUT
    input  wire logic        wb_valid_i,
    input  wire reg_addr_t   wb_reg_i,
    input  wire data_word_t  wb_data_i,
    input  wire rob_tag_t    wb_tag_i,

    // Forwarding answers
    input  wire data_word_t  fwd_result_i [2],
    input  wire logic        fwd_valid_i  [2],

    // Buffer occupancy flags seen by the execution paths
    input  wire logic        alu_full_i,
    input  wire logic        ld_full_i,

    // Wishbone slave responses
    input  wire logic        bus_ack_i,
    input  wire logic [31:0] bus_dat_i
);

    // Expected writebacks packed as register, tag and data
    logic [42:0] exp_q [$];
    logic [42:0] exp_head;

    int unsigned mismatch_count = 0;
    int unsigned other_count    = 0;
    int unsigned ack_count      = 0;
    logic        ack_seen       = 1'b0;

    // ==================================================
    // Error reporting
    // ==================================================

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        mismatch_count++;
        $display("MISMATCH at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, want);
    endtask

    task automatic report_problem(input string text);
        other_count++;
        $display("ERROR at %0t ns: %s", $time, text);
    endtask

    // ==================================================
    // Checks called by the replay
    // ==================================================

    task automatic expect_writeback(input reg_addr_t reg_a, input rob_tag_t tag,
                                    input data_word_t data);
        exp_q.push_back({reg_a, tag, data});
    endtask

    // Lookups are combinational, so the answer is read in the same cycle
    task automatic check_lookup(input int idx, input logic valid, input data_word_t data);
        if (fwd_valid_i[idx] !== valid) begin
            report_mismatch($sformatf("fwd_valid_o[%0d]", idx), fwd_valid_i[idx], valid);
        end
        if (fwd_result_i[idx] !== data) begin
            report_mismatch($sformatf("fwd_result_o[%0d]", idx), fwd_result_i[idx], data);
        end
    endtask

    task automatic check_read(input logic [1:0] adr, input logic [31:0] data);
        if (bus_dat_i !== data) begin
            report_mismatch($sformatf("wb_dat_o (offset %0d)", adr), bus_dat_i, data);
        end
        // STATUS holds the ALU full flag in bit 1 and the load full flag in bit 3
        if (adr == CSR_STATUS_ADDR) begin
            if (alu_full_i !== data[1]) begin
                report_mismatch("alu_full_o", alu_full_i, data[1]);
            end
            if (ld_full_i !== data[3]) begin
                report_mismatch("ld_full_o", ld_full_i, data[3]);
            end
        end
    endtask

    // Anything left in the queue never reached the register file
    task automatic final_check();
        logic [42:0] entry;
        while (exp_q.size() > 0) begin
            entry = exp_q.pop_front();
            report_problem($sformatf("writeback expected but never seen, x%0d tag %0d data 0x%0h",
                                     entry[42:38], entry[37:32], entry[31:0]));
        end
    endtask

    // ==================================================
    // Port monitor
    // ==================================================

    // Falling edge sampling keeps clear of the DUT's own updates
    always @(negedge clk_i) begin
        if (rst_n_i && wb_valid_i) begin
            if (exp_q.size() == 0) begin
                report_problem($sformatf("unexpected writeback to x%0d with tag %0d",
                                         wb_reg_i, wb_tag_i));
            end else begin
                exp_head = exp_q.pop_front();
                if (wb_reg_i !== exp_head[42:38]) begin
                    report_mismatch("wb_reg_o", wb_reg_i, exp_head[42:38]);
                end
                if (wb_tag_i !== exp_head[37:32]) begin
                    report_mismatch("wb_tag_o", wb_tag_i, exp_head[37:32]);
                end
                if (wb_data_i !== exp_head[31:0]) begin
                    report_mismatch("wb_data_o", wb_data_i, exp_head[31:0]);
                end
            end
        end
        // A classic slave acknowledges for exactly one cycle
        if (bus_ack_i) begin
            ack_count++;
            if (ack_seen) begin
                report_problem("wb_ack_o stayed high for more than one cycle");
            end
        end
        ack_seen = bus_ack_i;
    end

endmodule : commit_checker

`default_nettype wire

// ==== verif/commit_stage_golden.txt ====
# Hex fields. P push: path(0 alu,1 load) reg tag store data. L lookup: src0 src1 v0 d0 v1 d1
# W write / R read: adr data. E writeback: reg tag data. I idle: cycles. Lower case: same cycle
E 05 00 55
E 06 01 66
E 08 03 88
P 0 06 01 0 66
P 0 07 02 1 77
L 06 05 1 66 0 0
P 1 05 00 0 55
L 05 06 1 55 1 66
P 1 08 03 0 88
I 8
L 06 08 0 0 0 0
L 00 05 1 0 0 0
R 2 4
R 1 5
E 0c 04 cc
E 0a 05 aa
E 0a 06 bb
P 0 0a 05 0 aa
P 1 0c 04 0 cc
P 1 0a 06 0 bb
L 0a 0c 1 bb 0 0
L 0a 00 1 bb 1 0
I 4
L 0a 0a 0 0 0 0
P 0 02 08 0 22
P 1 01 07 0 11
w 0 2
L 01 02 1 11 1 22
I 6
R 1 0
R 0 2
E 01 07 11
E 02 08 22
W 0 0
I 6
R 2 9
P 0 04 0b 0 44
P 1 05 0c 0 55
L 04 05 1 44 1 55
W 0 1
R 1 5
R 2 0
L 04 05 0 0 0 0
E 09 00 99
P 0 09 00 0 99
I 4
R 2 1
W 2 0
R 2 0

// ==== verif/commit_stage_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module commit_stage_tb
    import commit_pkg::*;
();

    logic          clk;
    logic          rst_n;
    logic          alu_push;
    data_word_t    alu_result;
    instr_packet_t alu_packet;
    logic          alu_full;
    logic          ld_push;
    data_word_t    ld_result;
    instr_packet_t ld_packet;
    logic          ld_full;
    reg_addr_t     fwd_src    [2];
    data_word_t    fwd_result [2];
    logic          fwd_valid  [2];
    logic          wb_valid;
    reg_addr_t     wb_reg;
    data_word_t    wb_data;
    rob_tag_t      wb_tag;
    logic          wb_cyc;
    logic          wb_stb;
    logic          wb_we;
    logic [1:0]    wb_adr;
    logic [31:0]   wb_dat_w;
    logic [31:0]   wb_dat_r;
    logic          wb_ack;

    string       records [$];
    int unsigned n_records = 0;
    int unsigned bus_count = 0;

    commit_stage_top #(.BUFFER_DEPTH(8)) UUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .alu_push_i(alu_push), .alu_result_i(alu_result), .alu_packet_i(alu_packet),
        .alu_full_o(alu_full),
        .ld_push_i(ld_push), .ld_result_i(ld_result), .ld_packet_i(ld_packet),
        .ld_full_o(ld_full),
        .fwd_src_i(fwd_src), .fwd_result_o(fwd_result), .fwd_valid_o(fwd_valid),
        .wb_valid_o(wb_valid), .wb_reg_o(wb_reg), .wb_data_o(wb_data), .wb_tag_o(wb_tag),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
    );

    commit_checker u_checker (
        .clk_i(clk), .rst_n_i(rst_n),
        .wb_valid_i(wb_valid), .wb_reg_i(wb_reg), .wb_data_i(wb_data), .wb_tag_i(wb_tag),
        .fwd_result_i(fwd_result), .fwd_valid_i(fwd_valid),
        .alu_full_i(alu_full), .ld_full_i(ld_full),
        .bus_ack_i(wb_ack), .bus_dat_i(wb_dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==================================================
    // Driver tasks
    // ==================================================

    // Every new cycle starts with the push strobes released
    task automatic next_cycle();
        @(posedge clk);
        alu_push <= 1'b0;
        ld_push  <= 1'b0;
    endtask

    // Path 0 is the ALU buffer, path 1 the load buffer
    task automatic push_result(input logic path, input logic [31:0] reg_a,
                               input logic [31:0] tag, input logic store,
                               input logic [31:0] data);
        if (path) begin
            ld_push            <= 1'b1;
            ld_result          <= data;
            ld_packet.reg_dest <= reg_a[4:0];
            ld_packet.rob_tag  <= tag[5:0];
            ld_packet.is_store <= store;
        end else begin
            alu_push            <= 1'b1;
            alu_result          <= data;
            alu_packet.reg_dest <= reg_a[4:0];
            alu_packet.rob_tag  <= tag[5:0];
            alu_packet.is_store <= store;
        end
    endtask

    // The master holds its request until ack, then drops it on the next edge
    task automatic bus_access(input logic we, input logic [31:0] adr,
                              input logic [31:0] data);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr[1:0];
        wb_dat_w <= data;
        bus_count++;
        do begin
            next_cycle();
            @(negedge clk);
        end while (!wb_ack);
        if (!we) begin
            u_checker.check_read(adr[1:0], data);
        end
        next_cycle();
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    // Comment and blank lines are skipped, each other line is one record
    task automatic load_records();
        int    fd;
        string line;
        fd = $fopen("verif/commit_stage_golden.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) && line.len() > 1 && line.substr(0, 0) != "#") begin
                    records.push_back(line);
                end
            end
            $fclose(fd);
        end
        n_records = records.size();
    endtask

    // Lower case kinds share the cycle of the record before them
    task automatic replay_record(input string rec);
        logic [7:0]  kind;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        logic        same_cycle;
        void'($sscanf(rec, "%c %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5));
        same_cycle = (kind >= "a");
        if (same_cycle) begin
            kind = kind - 8'h20;
        end
        if (!same_cycle && kind != "E" && kind != "I") begin
            next_cycle();
        end
        case (kind)
            "P": push_result(f0[0], f1, f2, f3[0], f4);
            "L": begin
                fwd_src[0] <= f0[4:0];
                fwd_src[1] <= f1[4:0];
                @(negedge clk);
                u_checker.check_lookup(0, f2[0], f3);
                u_checker.check_lookup(1, f4[0], f5);
            end
            "W": bus_access(1'b1, f0, f1);
            "R": bus_access(1'b0, f0, f1);
            "E": u_checker.expect_writeback(f0[4:0], f1[5:0], f2);
            "I": repeat (f0) next_cycle();
            default: u_checker.report_problem($sformatf("unknown golden record: %s", rec));
        endcase
    endtask

    // ==================================================
    // Replay and final report
    // ==================================================

    initial begin : replay
        int unsigned total;
        rst_n      = 1'b0;
        alu_push   = 1'b0;
        alu_result = '0;
        alu_packet = '0;
        ld_push    = 1'b0;
        ld_result  = '0;
        ld_packet  = '0;
        fwd_src[0] = '0;
        fwd_src[1] = '0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        load_records();
        if (n_records == 0) begin
            $display("The golden file could not be opened or holds no records");
            $display("TEST FAIL");
        end else begin
            repeat (4) @(posedge clk);
            rst_n <= 1'b1;
            foreach (records[i]) begin
                replay_record(records[i]);
            end
            // Let the last results drain before the queue is judged
            repeat (10) next_cycle();
            u_checker.final_check();
            if (bus_count != u_checker.ack_count) begin
                u_checker.report_problem($sformatf("%0d bus accesses but %0d acks",
                                                   bus_count, u_checker.ack_count));
            end
            total = u_checker.mismatch_count + u_checker.other_count;
            $display("Errors: %0d mismatches, %0d other failures",
                     u_checker.mismatch_count, u_checker.other_count);
            if (total == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

    // Budget of twenty cycles for every golden record
    initial begin : watchdog
        wait (n_records > 0);
        repeat (20 * n_records) @(posedge clk);
        $display("Watchdog expired before the replay finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule : commit_stage_tb

`default_nettype wire
